// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@echo "no failure found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_RANDOM     = 150;
    localparam int TOTAL_REQS   = 3 + 8 + 3 + 8 + N_RANDOM;
    localparam int REQ_BOUND    = 40;   // worst case cycles per request

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      valid;
    cpu_req_t                  req;
    logic                      addr_ok;
    logic                      data_ok;
    logic [`CACHE_WORD_W-1:0]  rdata;
    logic                      rd_req;
    logic [`CACHE_ADDR_W-1:0]  rd_addr;
    logic                      rd_rdy;
    logic                      ret_valid;
    logic                      ret_last;
    logic [`CACHE_WORD_W-1:0]  ret_data;
    logic                      wr_req;
    logic [`CACHE_ADDR_W-1:0]  wr_addr;
    line_t                     wr_data;
    logic                      wr_rdy;
    logic [3:0]                max_delay;

    logic [7:0]  gold [bit [31:0]];   // golden byte memory
    bit          op_q [$];
    logic [31:0] exp_q [$];
    string       name_q [$];
    logic [31:0] wb_q [$];
    int          errors;
    int          checks;
    integer      seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top DUT (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .max_delay (max_delay),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    // contents of memory that was never written
    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] word;
        base = {addr[31:2], 2'b00};
        word = pattern_word(base);
        for (int i = 0; i < 4; i++) begin
            if (gold.exists(base + 32'(i)))
                word[8*i +: 8] = gold[base + 32'(i)];
        end
        return word;
    endfunction

    function automatic void golden_write(input logic [31:0] addr, input logic [3:0] strb,
                                         input logic [31:0] data);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                gold[base + 32'(i)] = data[8*i +: 8];
        end
    endfunction

    // called and returns on a falling edge, lat counts edges from accept to data_ok
    task automatic send_request(input bit op, input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data, input string name, output int lat);
        valid      = 1'b1;
        req.op     = op;
        req.tag    = addr[31:12];
        req.index  = addr[11:4];
        req.offset = addr[3:0];
        req.wstrb  = strb;
        req.wdata  = data;
        op_q.push_back(op);
        name_q.push_back(name);
        if (op) begin
            exp_q.push_back(32'h0);
            golden_write(addr, strb, data);
        end else begin
            exp_q.push_back(ref_read(addr));
        end
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        @(negedge clk);
        valid = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start)
            $display("test %-16s ok", name);
        else
            $display("test %-16s %0d error(s)", name, errors - err_start);
    endtask

    // compare at each data_ok
    always @(posedge clk) begin
        bit          is_write;
        logic [31:0] exp_word;
        string       tname;
        if (!reset && data_ok) begin
            if (op_q.size() == 0) begin
                $display("[ERROR] data_ok pulsed with no request outstanding");
                errors++;
            end else begin
                is_write = op_q.pop_front();
                exp_word = exp_q.pop_front();
                tname    = name_q.pop_front();
                if (!is_write) begin
                    checks++;
                    if (rdata !== exp_word) begin
                        $display("[ERROR] %s: rdata expected %h actual %h",
                                 tname, exp_word, rdata);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && wr_req && wr_rdy)
            wb_q.push_back(wr_addr);
    end

    initial begin
        repeat (RESET_CYCLES + TOTAL_REQS * REQ_BOUND) @(posedge clk);
        $display("watchdog: a request got no data_ok within %0d cycles on average", REQ_BOUND);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int          lat;
        int          e0;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] ev_line [4];
        bit          found;
        seed      = 32'h0cb1c1fc;
        reset     = 1'b1;
        valid     = 1'b0;
        req       = '0;
        max_delay = 4'd1;
        errors    = 0;
        checks    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        e0 = errors;
        checks++;
        if ({addr_ok, data_ok, rd_req, wr_req} !== 4'b1000) begin
            $display("[ERROR] reset_state: {addr_ok,data_ok,rd_req,wr_req} expected 1000 actual %b",
                     {addr_ok, data_ok, rd_req, wr_req});
            errors++;
        end
        report_test("reset_state", e0);

        e0 = errors;
        send_request(1'b0, 32'h0001_2108, 4'h0, 32'h0, "cold_read_miss", lat);
        send_request(1'b0, 32'h0001_2108, 4'h0, 32'h0, "cold_read_miss", lat);
        checks++;
        if (lat != 1) begin
            $display("[ERROR] cold_read_miss: hit latency expected 1 actual %0d", lat);
            errors++;
        end
        send_request(1'b0, 32'h0001_210c, 4'h0, 32'h0, "cold_read_miss", lat);
        report_test("cold_read_miss", e0);

        e0 = errors;
        send_request(1'b1, 32'h0001_2100, 4'b0001, 32'hdead_beef, "write_hit", lat);
        send_request(1'b1, 32'h0001_2104, 4'b0110, 32'h1234_5678, "write_hit", lat);
        send_request(1'b1, 32'h0001_2108, 4'b1111, 32'hcafe_f00d, "write_hit", lat);
        send_request(1'b1, 32'h0001_210c, 4'b1001, 32'ha5a5_5a5a, "write_hit", lat);
        for (int i = 0; i < 4; i++) begin
            send_request(1'b0, 32'h0001_2100 + 32'(4 * i), 4'h0, 32'h0, "write_hit", lat);
        end
        report_test("write_hit", e0);

        e0 = errors;
        send_request(1'b1, 32'h0003_4204, 4'b1010, 32'h7788_99aa, "write_miss", lat);
        send_request(1'b0, 32'h0003_4204, 4'h0, 32'h0, "write_miss", lat);
        send_request(1'b0, 32'h0003_4200, 4'h0, 32'h0, "write_miss", lat);
        report_test("write_miss", e0);

        // four tags into a two-way set
        e0 = errors;
        wb_q.delete();
        for (int i = 0; i < 4; i++) begin
            ev_line[i] = {20'h0a000 + 20'(i), 8'h80, 4'h0};
            send_request(1'b1, ev_line[i] + 32'h4, 4'hf, 32'hbeef_0000 + 32'(i), "eviction", lat);
        end
        for (int i = 0; i < 4; i++) begin
            send_request(1'b0, ev_line[i] + 32'h4, 4'h0, 32'h0, "eviction", lat);
        end
        checks++;
        if (wb_q.size() == 0) begin
            $display("[ERROR] eviction: no writeback seen after evicting dirty lines");
            errors++;
        end
        foreach (wb_q[k]) begin
            found = 1'b0;
            for (int i = 0; i < 4; i++) begin
                if (wb_q[k] == ev_line[i])
                    found = 1'b1;
            end
            checks++;
            if (!found) begin
                $display("[ERROR] eviction: wr_addr expected a written line actual %h", wb_q[k]);
                errors++;
            end
        end
        report_test("eviction", e0);

        e0 = errors;
        max_delay = 4'd3;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            a = {20'h00100 | {18'h0, r[1:0]}, 8'h40 | {6'h0, r[3:2]}, r[5:4], 2'b00};
            send_request(r[6], a, r[10:7], $random(seed), "random_traffic", lat);
        end
        report_test("random_traffic", e0);

        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module mem_model import cache_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [3:0]                 max_delay,
    input  wire                       rd_req,
    input  wire [`CACHE_ADDR_W-1:0]   rd_addr,
    output logic                      rd_rdy,
    output logic                      ret_valid,
    output logic                      ret_last,
    output logic [`CACHE_WORD_W-1:0]  ret_data,
    input  wire                       wr_req,
    input  wire [`CACHE_ADDR_W-1:0]   wr_addr,
    input  wire line_t                wr_data,
    output logic                      wr_rdy
);

    logic [31:0] mem [bit [29:0]];   // sparse, keyed by word address
    integer      seed;
    logic [31:0] line_addr;

    // untouched memory reads back this pattern
    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [31:0] read_word(input logic [29:0] wa);
        if (mem.exists(wa))
            return mem[wa];
        return pattern_word({wa, 2'b00});
    endfunction

    task automatic random_wait();
        int n;
        n = $random(seed);
        n = (n & 32'h7fff_ffff) % (int'(max_delay) + 1);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        seed      = 32'h0cb1c1fc;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && wr_req) begin
                random_wait();
                wr_rdy = 1'b1;   // absorb the whole victim line
                for (int b = 0; b < `CACHE_BANKS; b++) begin
                    mem[{wr_addr[31:4], 2'(b)}] = wr_data[b];
                end
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (!reset && rd_req) begin
                line_addr = rd_addr;
                random_wait();
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int b = 0; b < `CACHE_BANKS; b++) begin
                    random_wait();   // gaps between beats
                    ret_valid = 1'b1;
                    ret_last  = (b == `CACHE_BANKS - 1);
                    ret_data  = read_word({line_addr[31:4], 2'(b)});
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cache/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl import cache_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      valid,
    input  wire cpu_req_t            req,
    input  wire [`CACHE_WAYS-1:0]    way_hit,
    input  wire                      victim_dirty,
    input  wire                      wr_rdy,
    input  wire                      rd_rdy,
    input  wire                      ret_valid,
    input  wire                      ret_last,
    output cache_state_t             state,
    output cpu_req_t                 buf_req,
    output logic [1:0]               ret_bank,
    output logic                     victim_way,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic                     wr_req,
    output logic                     rd_req
);

    cache_state_t state_next;
    logic         accept;
    logic         hit;
    logic         miss_done;
    logic         fill_done;
    logic [7:0]   lfsr;

    assign addr_ok   = (state == IDLE);
    assign accept    = valid && addr_ok;
    assign hit       = |way_hit;
    assign wr_req    = (state == MISS) && victim_dirty;    // held until wr_rdy
    assign rd_req    = (state == REPLACE);
    assign miss_done = !victim_dirty || wr_rdy;
    assign fill_done = (state == REFILL) && ret_valid && ret_last;

    // hit ends in lookup, miss ends on the requested beat
    assign data_ok = ((state == LOOKUP) && hit)
                   || ((state == REFILL) && ret_valid && (ret_bank == buf_req.offset[3:2]));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept)
                    state_next = LOOKUP;
            end
            LOOKUP: begin
                state_next = hit ? IDLE : MISS;
            end
            MISS: begin
                if (miss_done)
                    state_next = REPLACE;
            end
            REPLACE: begin
                if (rd_rdy)
                    state_next = REFILL;
            end
            REFILL: begin
                if (fill_done)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (accept)
            buf_req <= req;
    end

    // refill beat number
    always_ff @(posedge clk) begin
        if (reset)
            ret_bank <= 2'd0;
        else if (state == REPLACE)
            ret_bank <= 2'd0;
        else if ((state == REFILL) && ret_valid)
            ret_bank <= ret_bank + 2'd1;
    end

    // victim is frozen for the whole miss, lfsr steps once per miss
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr       <= `CACHE_LFSR_SEED;
            victim_way <= 1'b0;
        end else begin
            if ((state == LOOKUP) && !hit)
                victim_way <= lfsr[0];
            if ((state == MISS) && miss_done)
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};  // x^8+x^6+x^5+x^4+1
        end
    end

    // victim state must not move while the writeback waits
    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        (wr_req && !wr_rdy) |=> wr_req);

    // beat counter lines up with the last beat, so every offset got its data_ok
    a_last_beat: assert property (@(posedge clk) disable iff (reset)
        fill_done |-> (ret_bank == 2'(`CACHE_BANKS - 1)));

endmodule

`default_nettype wire

// File: cache/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top import cache_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        valid,
    input  wire cpu_req_t              req,
    output logic                       addr_ok,
    output logic                       data_ok,
    output logic [`CACHE_WORD_W-1:0]   rdata,
    output logic                       rd_req,
    output logic [`CACHE_ADDR_W-1:0]   rd_addr,
    input  wire                        rd_rdy,
    input  wire                        ret_valid,
    input  wire                        ret_last,
    input  wire [`CACHE_WORD_W-1:0]    ret_data,
    output logic                       wr_req,
    output logic [`CACHE_ADDR_W-1:0]   wr_addr,
    output line_t                      wr_data,
    input  wire                        wr_rdy
);

    cache_state_t               state;
    cpu_req_t                   buf_req;
    logic [1:0]                 ret_bank;
    logic                       victim_way;
    logic [`CACHE_WAYS-1:0]     way_hit;
    logic                       victim_dirty;
    logic [`CACHE_TAG_W-1:0]    victim_tag;
    logic [`CACHE_WORD_W-1:0]   hit_word;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .req          (req),
        .way_hit      (way_hit),
        .victim_dirty (victim_dirty),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .state        (state),
        .buf_req      (buf_req),
        .ret_bank     (ret_bank),
        .victim_way   (victim_way),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .wr_req       (wr_req),
        .rd_req       (rd_req)
    );

    tag_array u_tag (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .req          (req),
        .buf_req      (buf_req),
        .victim_way   (victim_way),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .way_hit      (way_hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_array u_data (
        .clk          (clk),
        .state        (state),
        .req          (req),
        .buf_req      (buf_req),
        .way_hit      (way_hit),
        .victim_way   (victim_way),
        .ret_bank     (ret_bank),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .hit_word     (hit_word),
        .victim_line  (wr_data)
    );

    // line aligned transfers
    assign rd_addr = {buf_req.tag, buf_req.index, {`CACHE_OFS_W{1'b0}}};
    assign wr_addr = {victim_tag, buf_req.index, {`CACHE_OFS_W{1'b0}}};

    assign rdata = (state == REFILL) ? ret_data : hit_word;

endmodule

`default_nettype wire

// File: cache/data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module data_array import cache_pkg::*; (
    input  wire                       clk,
    input  wire cache_state_t         state,
    input  wire cpu_req_t             req,
    input  wire cpu_req_t             buf_req,
    input  wire [`CACHE_WAYS-1:0]     way_hit,
    input  wire                       victim_way,
    input  wire [1:0]                 ret_bank,
    input  wire                       ret_valid,
    input  wire [`CACHE_WORD_W-1:0]   ret_data,
    output logic [`CACHE_WORD_W-1:0]  hit_word,
    output line_t                     victim_line
);

    localparam int NBYTES = `CACHE_WORD_W / 8;

    wire line_t                way_line [`CACHE_WAYS];
    logic [`CACHE_IDX_W-1:0]   rd_idx;
    logic [1:0]                req_bank;
    logic                      hit_write;
    logic                      fill_beat;
    logic [`CACHE_WORD_W-1:0]  merged;
    logic [`CACHE_WORD_W-1:0]  fill_word;

    assign rd_idx    = (state == IDLE) ? req.index : buf_req.index;
    assign req_bank  = buf_req.offset[3:2];
    assign hit_write = (state == LOOKUP) && buf_req.op;
    assign fill_beat = (state == REFILL) && ret_valid;

    // buffered store bytes laid over the returning beat
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            merged[8*i +: 8] = buf_req.wstrb[i] ? buf_req.wdata[8*i +: 8] : ret_data[8*i +: 8];
        end
    end

    assign fill_word = (buf_req.op && (ret_bank == req_bank)) ? merged : ret_data;

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            logic [`CACHE_WORD_W-1:0] bank_mem [`CACHE_SETS];
            logic [`CACHE_WORD_W-1:0] rd_word;
            logic                     hit_we;
            logic                     fill_we;

            assign hit_we  = hit_write && way_hit[w] && (req_bank == 2'(b));
            assign fill_we = fill_beat && (victim_way == 1'(w)) && (ret_bank == 2'(b));

            always_ff @(posedge clk) begin
                if (fill_we) begin
                    bank_mem[buf_req.index] <= fill_word;
                end else begin
                    for (int i = 0; i < NBYTES; i++) begin
                        if (hit_we && buf_req.wstrb[i])
                            bank_mem[buf_req.index][8*i +: 8] <= buf_req.wdata[8*i +: 8];
                    end
                end
                rd_word <= bank_mem[rd_idx];
            end

            assign way_line[w][b] = rd_word;
        end
    end

    // way_hit is one-hot or zero
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w])
                hit_word = hit_word | way_line[w][req_bank];
        end
    end

    assign victim_line = way_line[victim_way];   // read during lookup, stable through miss

endmodule

`default_nettype wire

// File: cache/tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tag_array import cache_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  wire cache_state_t         state,
    input  wire cpu_req_t             req,
    input  wire cpu_req_t             buf_req,
    input  wire                       victim_way,
    input  wire                       ret_valid,
    input  wire                       ret_last,
    output logic [`CACHE_WAYS-1:0]    way_hit,
    output logic                      victim_dirty,
    output logic [`CACHE_TAG_W-1:0]   victim_tag
);

    logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0]  valid_q [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0]  dirty_q [`CACHE_WAYS];
    tagv_t                   rd_q    [`CACHE_WAYS];
    logic [`CACHE_IDX_W-1:0] rd_idx;
    logic                    hit_write;
    logic                    fill_done;

    // live index while idle so lookup sees the new set
    assign rd_idx    = (state == IDLE) ? req.index : buf_req.index;
    assign hit_write = (state == LOOKUP) && buf_req.op;
    assign fill_done = (state == REFILL) && ret_valid && ret_last;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = (state == LOOKUP) && rd_q[w].valid && (rd_q[w].tag == buf_req.tag);
        end
    end

    assign victim_tag   = rd_q[victim_way].tag;
    assign victim_dirty = rd_q[victim_way].valid && dirty_q[victim_way][buf_req.index];

    always_ff @(posedge clk) begin
        if (fill_done)
            tag_mem[victim_way][buf_req.index] <= buf_req.tag;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            rd_q[w] <= '{tag: tag_mem[w][rd_idx], valid: valid_q[w][rd_idx]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (hit_write && way_hit[w])
                    dirty_q[w][buf_req.index] <= 1'b1;
            end
            if (fill_done) begin
                valid_q[victim_way][buf_req.index] <= 1'b1;
                dirty_q[victim_way][buf_req.index] <= buf_req.op;  // write miss leaves it dirty
            end
        end
    end

    // a refill must never duplicate a resident tag
    a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// File: common/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address split
`define CACHE_TAG_W     20
`define CACHE_IDX_W     8
`define CACHE_OFS_W     4
`define CACHE_ADDR_W    (`CACHE_TAG_W + `CACHE_IDX_W + `CACHE_OFS_W)

`define CACHE_SETS      (1 << `CACHE_IDX_W)

// data geometry
`define CACHE_WORD_W    32
`define CACHE_BANKS     4   // words per line
`define CACHE_WAYS      2

// victim lfsr start value, must be nonzero
`define CACHE_LFSR_SEED 8'h5a

`endif

// File: common/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    // cpu request as captured at acceptance
    typedef struct packed {
        logic                         op;       // 1 = write
        logic [`CACHE_TAG_W-1:0]      tag;
        logic [`CACHE_IDX_W-1:0]      index;
        logic [`CACHE_OFS_W-1:0]      offset;
        logic [`CACHE_WORD_W/8-1:0]   wstrb;
        logic [`CACHE_WORD_W-1:0]     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]      tag;
        logic                         valid;
    } tagv_t;

    // bank 0 sits in the low word
    typedef logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0] line_t;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } cache_state_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+common
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/tag_array.sv
cache/data_array.sv
cache/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv
